// File: hdl/div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

`default_nettype none

// ------------------------------------------------------------------------
// fixed-point formats
// ------------------------------------------------------------------------
`define DIV_IN_I   8                        // input integer bits, sign included
`define DIV_IN_F   8                        // input fraction bits
`define DIV_IN_W   (`DIV_IN_I + `DIV_IN_F)

// unsigned quotient magnitude, Q16.8
`define DIV_QUO_W  (`DIV_IN_W + `DIV_IN_F)

`define DIV_OUT_I  4                        // output integer bits, sign included
`define DIV_OUT_F  12                       // output fraction bits
`define DIV_OUT_W  (`DIV_OUT_I + `DIV_OUT_F)

// ------------------------------------------------------------------------
// register block
// ------------------------------------------------------------------------
`define DIV_CNT_W      16                   // event counter width
`define DIV_CSR_AW     2
`define DIV_CSR_DW     32
`define DIV_ADDR_CTRL  2'd0                 // bit0 sat_en, bit1 zero_policy
`define DIV_ADDR_STAT  2'd1                 // {sat count, done count}, div-by-zero count at +1

`default_nettype wire

`endif

// File: hdl/fxp_pkg.sv
`default_nettype none

`include "div_cfg.svh"

package fxp_pkg;

    // ------------------------------------------------------------------------
    // fixed-point words
    // ------------------------------------------------------------------------

    // Q8.8 operand
    typedef logic signed [`DIV_IN_W-1:0] div_in_t;

    // Q4.12 result
    typedef logic signed [`DIV_OUT_W-1:0] div_out_t;

    // unsigned Q16.8, what the iterative core hands back
    typedef logic [`DIV_QUO_W-1:0] div_mag_t;

    // ------------------------------------------------------------------------
    // transfer structs
    // ------------------------------------------------------------------------

    // operand pair, numerator in the upper half
    typedef struct packed {
        div_in_t num;
        div_in_t den;
    } div_req_t;

    // signed quotient before format conversion
    // {sign, val} read together is one two's complement word
    typedef struct packed {
        logic     sign;
        div_mag_t val;                      // low bits of the signed Q16.8 value
    } div_raw_t;

    // final result as seen on the response port
    typedef struct packed {
        div_out_t quo;
        logic     div_by_zero;
        logic     saturated;                // out of Q4.12 range, clamped or wrapped
    } div_rsp_t;

endpackage

`default_nettype wire

// File: hdl/div_csr_pkg.sv
`default_nettype none

`include "div_cfg.svh"

package div_csr_pkg;

    // ------------------------------------------------------------------------
    // control fields
    // ------------------------------------------------------------------------

    // sat_en sits in bit 0 of the CTRL word
    typedef struct packed {
        logic zero_policy;                  // 0 -> zero, 1 -> signed full scale
        logic sat_en;                       // clamp instead of wrap
    } div_ctrl_t;

    // ------------------------------------------------------------------------
    // register port
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic                   write;
        logic [`DIV_CSR_AW-1:0] addr;
        logic [`DIV_CSR_DW-1:0] wdata;
    } csr_req_t;

    // read data, returned one cycle after accept
    typedef struct packed {
        logic [`DIV_CSR_DW-1:0] rdata;
    } csr_rsp_t;

endpackage

`default_nettype wire

// File: hdl/divu_core.sv
`default_nettype none

// unsigned restoring divider, quo = floor(a * 2^FBITS / b)
// one quotient bit per clock, WIDTH+FBITS clocks per divide
module divu_core #(
    parameter int WIDTH = 16,
    parameter int FBITS = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,   // single-cycle, also runs iteration 1
    output logic                   busy,
    output logic                   done,    // high one cycle, quo valid from here
    input  logic [WIDTH-1:0]       a,       // dividend
    input  logic [WIDTH-1:0]       b,       // divisor
    output logic [WIDTH+FBITS-1:0] quo
);

    localparam int QW = WIDTH + FBITS;      // iteration count = quotient bits
    localparam int CW = $clog2(QW);

    logic [CW-1:0]    cnt;                  // iterations already done
    logic [WIDTH-1:0] b_q;
    logic [WIDTH-1:0] rem_q;                // partial remainder, always < b
    logic [QW-1:0]    qr_q;                 // dividend bits out the top, quotient in the bottom

    logic [WIDTH-1:0] rem_in, div_in, rem_nx;
    logic [QW-1:0]    qr_in, qr_nx;
    logic [WIDTH:0]   trial;                // one bit wider for the shift-in
    logic             ge;
    logic             step;

    assign step = start | busy;
    assign quo  = qr_q;

    // ------------------------------------------------------------------------
    // one restoring step
    // ------------------------------------------------------------------------
    always_comb begin
        // on start take operands straight from the ports
        rem_in = start ? '0 : rem_q;
        qr_in  = start ? (QW'(a) << FBITS) : qr_q;
        div_in = start ? b : b_q;

        trial = {rem_in, qr_in[QW-1]};      // shift next dividend bit in
        ge    = (trial >= {1'b0, div_in});
        if (ge) begin
            rem_nx = WIDTH'(trial - {1'b0, div_in});
        end else begin
            rem_nx = trial[WIDTH-1:0];      // restore, keep shifted value
        end
        qr_nx = {qr_in[QW-2:0], ge};
    end

    // iteration control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= CW'(1);             // first step taken with start
            end else if (busy) begin
                if (cnt == CW'(QW - 1)) begin
                    busy <= 1'b0;           // last bit lands this edge
                    done <= 1'b1;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (step) begin
            rem_q <= rem_nx;
            qr_q  <= qr_nx;
            b_q   <= div_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/q_convert.sv
`default_nettype none

`include "div_cfg.svh"

// signed Q16.8 (sign + 24 bits) to Q4.12, clamp or wrap on overflow
module q_convert #(
    parameter int IN_I  = `DIV_IN_I,
    parameter int IN_F  = `DIV_IN_F,
    parameter int OUT_I = `DIV_OUT_I,
    parameter int OUT_F = `DIV_OUT_F
) (
    input  fxp_pkg::div_raw_t raw,
    input  logic              sat_en,
    output fxp_pkg::div_out_t quo,
    output logic              saturated
);

    import fxp_pkg::*;

    // raw word: sign, IN_I+IN_F integer bits, IN_F fraction bits
    localparam int RAW_W = IN_I + 2 * IN_F + 1;
    localparam int OUT_W = OUT_I + OUT_F;
    localparam int SH    = OUT_F - IN_F;    // extra fraction bits
    localparam int EXT_W = RAW_W + SH;

    localparam div_out_t MAX_POS = {1'b0, {(OUT_W-1){1'b1}}};
    localparam div_out_t MAX_NEG = {1'b1, {(OUT_W-1){1'b0}}};

    logic [EXT_W-1:0]       ext;            // raw aligned to output fraction
    logic [EXT_W-OUT_W:0]   top;            // bits that must all match the sign
    logic                   fits;

    // ------------------------------------------------------------------------
    // alignment and range check
    // ------------------------------------------------------------------------
    assign ext  = EXT_W'(raw) << SH;
    assign top  = ext[EXT_W-1:OUT_W-1];
    assign fits = (top == '0) || (top == '1);

    always_comb begin
        saturated = !fits;                  // also set when wrapping
        if (fits || !sat_en) begin
            quo = ext[OUT_W-1:0];           // in range, or wrap to low bits
        end else if (raw.sign) begin
            quo = MAX_NEG;
        end else begin
            quo = MAX_POS;
        end
    end

endmodule

`default_nettype wire

// File: hdl/fxp_signed_div.sv
`default_nettype none

`include "div_cfg.svh"

// signed front end around divu_core
// strips signs on accept, puts them back on done, holds result until taken
module fxp_signed_div (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  fxp_pkg::div_req_t req,
    input  logic              zero_policy,
    output logic              raw_valid,
    input  logic              raw_ready,
    output fxp_pkg::div_raw_t raw,
    output logic              div_by_zero,
    output logic              done_evt,
    output logic              zero_evt
);

    import fxp_pkg::*;

    localparam int IN_W  = $bits(div_in_t);
    localparam int RAW_W = $bits(div_raw_t);

    logic            accept, raw_hs;
    logic            acc_d;                 // accept delayed one cycle
    logic            pend;                  // operand taken, result not yet handed off
    logic            start, busy, done;
    logic            sign_q;                // quotient sign
    logic            sign_n;                // numerator sign, for full scale
    logic            dz_q;
    logic [IN_W-1:0] mag_n, mag_d;
    div_mag_t        quo_mag;
    logic [RAW_W-1:0] raw_next;

    // |x| as unsigned, -128.0 gives 0x8000 which is right
    function automatic logic [IN_W-1:0] magnitude(input div_in_t x);
        magnitude = x[IN_W-1] ? IN_W'(-x) : IN_W'(x);
    endfunction

    assign accept   = req_valid & req_ready;
    assign raw_hs   = raw_valid & raw_ready;
    assign done_evt = done;
    assign zero_evt = done & dz_q;

    // ------------------------------------------------------------------------
    // handshake and sequencing
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_ready <= 1'b0;              // comes up one cycle after reset
            pend      <= 1'b0;
            acc_d     <= 1'b0;
            start     <= 1'b0;
            raw_valid <= 1'b0;
        end else begin
            acc_d <= accept;
            start <= acc_d;                 // start pulses after the edge past accept
            if (accept) begin
                pend <= 1'b1;
            end else if (raw_hs) begin
                pend <= 1'b0;
            end
            req_ready <= !accept && !busy && (!pend || raw_hs);
            if (done) begin
                raw_valid <= 1'b1;
            end else if (raw_hs) begin
                raw_valid <= 1'b0;
            end
        end
    end

    // operand capture and result register
    always_ff @(posedge clk) begin
        if (accept) begin
            sign_n <= req.num[IN_W-1];
            sign_q <= req.num[IN_W-1] ^ req.den[IN_W-1];
            dz_q   <= (req.den == '0);
            mag_n  <= magnitude(req.num);
            mag_d  <= magnitude(req.den);
        end
        if (done) begin
            raw         <= div_raw_t'(raw_next);
            div_by_zero <= dz_q;
        end
    end

    // ------------------------------------------------------------------------
    // sign restore and divide-by-zero substitution
    // ------------------------------------------------------------------------
    always_comb begin
        if (dz_q) begin
            // full scale = most positive / most negative raw word
            raw_next = zero_policy ? {sign_n, {(RAW_W-1){~sign_n}}} : '0;
        end else if (sign_q) begin
            raw_next = -{1'b0, quo_mag};
        end else begin
            raw_next = {1'b0, quo_mag};
        end
    end

    divu_core #(
        .WIDTH (IN_W),
        .FBITS (`DIV_IN_F)
    ) i_divu_core (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done),
        .a     (mag_n),
        .b     (mag_d),
        .quo   (quo_mag)
    );

endmodule

`default_nettype wire

// File: hdl/div_csr.sv
`default_nettype none

`include "div_cfg.svh"

// CTRL register plus done / saturate / div-by-zero event counters
module div_csr (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   csr_valid,
    output logic                   csr_ready,
    input  div_csr_pkg::csr_req_t  csr_req,
    output logic                   csr_rvalid,
    output div_csr_pkg::csr_rsp_t  csr_rsp,
    output div_csr_pkg::div_ctrl_t ctrl,
    input  logic                   done_evt,
    input  logic                   sat_evt,
    input  logic                   zero_evt
);

    import div_csr_pkg::*;

    localparam logic [`DIV_CSR_AW-1:0] ADDR_ZERO = `DIV_ADDR_STAT + 2'd1;
    localparam int CW = `DIV_CNT_W;
    localparam int DW = $bits(csr_rsp_t);

    logic          wr_ctrl, clr, rd;
    logic [CW-1:0] done_cnt, sat_cnt, zero_cnt;
    logic [DW-1:0] rd_word;

    // stick at all ones
    function automatic logic [CW-1:0] bump(input logic [CW-1:0] c, input logic ev);
        bump = (ev && c != '1) ? c + 1'b1 : c;
    endfunction

    assign csr_ready = 1'b1;                // never stalls
    assign rd        = csr_valid & ~csr_req.write;
    assign wr_ctrl   = csr_valid & csr_req.write & (csr_req.addr == `DIV_ADDR_CTRL);
    assign clr       = csr_valid & csr_req.write & (csr_req.addr == `DIV_ADDR_STAT);

    // ------------------------------------------------------------------------
    // control and counters
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl       <= '{zero_policy: 1'b0, sat_en: 1'b1};
            done_cnt   <= '0;
            sat_cnt    <= '0;
            zero_cnt   <= '0;
            csr_rvalid <= 1'b0;
        end else begin
            csr_rvalid <= rd;
            if (wr_ctrl) begin
                ctrl <= div_ctrl_t'(csr_req.wdata[$bits(div_ctrl_t)-1:0]);
            end
            if (clr) begin                  // any write to STAT, wins over events
                done_cnt <= '0;
                sat_cnt  <= '0;
                zero_cnt <= '0;
            end else begin
                done_cnt <= bump(done_cnt, done_evt);
                sat_cnt  <= bump(sat_cnt, sat_evt);
                zero_cnt <= bump(zero_cnt, zero_evt);
            end
        end
    end

    // read mux, registered below
    always_comb begin
        case (csr_req.addr)
            `DIV_ADDR_CTRL: rd_word = DW'(ctrl);
            `DIV_ADDR_STAT: rd_word = DW'({sat_cnt, done_cnt});
            ADDR_ZERO:      rd_word = DW'(zero_cnt);
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            csr_rsp.rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_unit_top.sv
`default_nettype none

// divider, format converter and register block
module div_unit_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fxp_pkg::div_req_t     req,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output fxp_pkg::div_rsp_t     rsp,
    input  logic                  csr_valid,
    output logic                  csr_ready,
    input  div_csr_pkg::csr_req_t csr_req,
    output logic                  csr_rvalid,
    output div_csr_pkg::csr_rsp_t csr_rsp
);

    import fxp_pkg::*;
    import div_csr_pkg::*;

    div_raw_t  raw;
    div_out_t  quo;
    div_ctrl_t ctrl;
    logic      div_by_zero, saturated;
    logic      done_evt, zero_evt, sat_evt;

    // ------------------------------------------------------------------------
    // result assembly
    // ------------------------------------------------------------------------
    assign rsp.quo         = quo;
    assign rsp.div_by_zero = div_by_zero;
    assign rsp.saturated   = saturated;
    assign sat_evt         = rsp_valid & rsp_ready & saturated;  // count on handoff only

    fxp_signed_div i_signed_div (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req         (req),
        .zero_policy (ctrl.zero_policy),
        .raw_valid   (rsp_valid),
        .raw_ready   (rsp_ready),
        .raw         (raw),
        .div_by_zero (div_by_zero),
        .done_evt    (done_evt),
        .zero_evt    (zero_evt)
    );

    q_convert i_q_convert (
        .raw       (raw),
        .sat_en    (ctrl.sat_en),
        .quo       (quo),
        .saturated (saturated)
    );

    div_csr i_div_csr (
        .clk        (clk),
        .rst        (rst),
        .csr_valid  (csr_valid),
        .csr_ready  (csr_ready),
        .csr_req    (csr_req),
        .csr_rvalid (csr_rvalid),
        .csr_rsp    (csr_rsp),
        .ctrl       (ctrl),
        .done_evt   (done_evt),
        .sat_evt    (sat_evt),
        .zero_evt   (zero_evt)
    );

endmodule

`default_nettype wire

// File: testbench/div_ref_model.svh
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

`default_nettype none

`include "div_cfg.svh"

// ------------------------------------------------------------------------
// testbench constants
// ------------------------------------------------------------------------
`define TB_SEED       32'he7a6_13fc
`define TB_RSP_LAT    26                    // accept edge to first rsp_valid edge
`define TB_TXN_MAX    200
`define TB_TXN_CYC    40                    // worst case per transaction, back-pressure included
`define TB_CYC_LIMIT  (`TB_TXN_MAX * `TB_TXN_CYC)

function automatic longint abs_val(input longint x);
    return (x < 0) ? -x : x;
endfunction

// expected response for one request, straight from the arithmetic rules
function automatic fxp_pkg::div_rsp_t ref_divide(
    input fxp_pkg::div_in_t num,
    input fxp_pkg::div_in_t den,
    input logic             sat_en,
    input logic             zero_policy
);
    longint            n, d, q, v, hi, lo;
    fxp_pkg::div_rsp_t r;
    n  = longint'(num);                     // sign extended
    d  = longint'(den);
    hi = (longint'(1) << (`DIV_OUT_W - 1)) - 1;
    lo = -(longint'(1) << (`DIV_OUT_W - 1));
    if (d == 0) begin
        if (!zero_policy) begin
            q = 0;
        end else if (n < 0) begin
            q = -(longint'(1) << `DIV_QUO_W);   // signed Q16.8 full scale
        end else begin
            q = (longint'(1) << `DIV_QUO_W) - 1;
        end
    end else begin
        q = (abs_val(n) << `DIV_IN_F) / abs_val(d);  // truncate toward zero
        if ((n < 0) != (d < 0)) begin
            q = -q;
        end
    end
    v = q * (longint'(1) << (`DIV_OUT_F - `DIV_IN_F));  // Q.8 to Q.12
    r.div_by_zero = (d == 0);
    r.saturated   = (v > hi) || (v < lo);
    if (r.saturated && sat_en) begin
        r.quo = (v > 0) ? hi[`DIV_OUT_W-1:0] : lo[`DIV_OUT_W-1:0];
    end else begin
        r.quo = v[`DIV_OUT_W-1:0];          // wrap
    end
    return r;
endfunction

`default_nettype wire

`endif

// File: testbench/tb_div_unit.sv
`include "div_ref_model.svh"

`default_nettype none

module tb_div_unit;

    import fxp_pkg::*;
    import div_csr_pkg::*;

    logic        clk;
    logic        rst;
    logic        req_valid;
    logic        req_ready;
    div_req_t    req;
    logic        rsp_valid;
    logic        rsp_ready = 1'b0;
    div_rsp_t    rsp;
    logic        csr_valid;
    logic        csr_ready;
    csr_req_t    csr_req;
    logic        csr_rvalid;
    csr_rsp_t    csr_rsp;

    // stimulus side
    logic        bp_en;                     // random back-pressure on rsp_ready
    logic        sat_en_m, zpol_m;          // shadow of CTRL
    logic [31:0] exp_rdata;
    int          n_rd;
    int unsigned seed_val;

    // monitor side
    div_rsp_t    sb_q[$];
    div_rsp_t    exp_head    = '0;
    div_rsp_t    rsp_q       = '0;
    logic        in_flight   = 1'b0;
    logic        held_q      = 1'b0;        // rsp stalled last edge
    logic        rsp_valid_d = 1'b0;
    int          since_acc   = 0;
    int          n_acc       = 0;
    int          n_rsp       = 0;
    int          n_rvalid    = 0;
    int          n_done      = 0;
    int          n_sat       = 0;
    int          n_zero      = 0;
    int          cycles      = 0;

    div_unit_top i_div_unit_top (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= `TB_CYC_LIMIT) begin
            stop_run("timeout: the run did not finish within its cycle limit");
        end
    end

    always @(posedge clk) begin
        rsp_ready <= bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
    end

    // ------------------------------------------------------------------------
    // monitor and scoreboard
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        rsp_valid_d <= rsp_valid;
        held_q      <= rsp_valid && !rsp_ready;
        rsp_q       <= rsp;
        since_acc   <= since_acc + 1;
        if (!rst && req_valid && req_ready) begin
            sb_q.push_back(ref_divide(req.num, req.den, sat_en_m, zpol_m));
            exp_head  <= sb_q[0];           // one in flight, so head is the new entry
            in_flight <= 1'b1;
            since_acc <= 0;
            n_acc     <= n_acc + 1;
        end
        if (!rst && rsp_valid && rsp_ready && sb_q.size() != 0) begin
            n_done    <= n_done + 1;
            n_sat     <= n_sat + int'(sb_q[0].saturated);
            n_zero    <= n_zero + int'(sb_q[0].div_by_zero);
            n_rsp     <= n_rsp + 1;
            in_flight <= 1'b0;
            sb_q.delete(0);
        end
        if (!rst && csr_rvalid) begin
            n_rvalid <= n_rvalid + 1;
        end
        // any STAT write clears the counters
        if (!rst && csr_valid && csr_req.write && csr_req.addr == `DIV_ADDR_STAT) begin
            n_done <= 0;
            n_sat  <= 0;
            n_zero <= 0;
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    a_rsp_value: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && rsp_ready) |-> (in_flight && rsp == exp_head))
        else stop_run($sformatf("Mismatch at %0t: rsp %h, expected %h",
                                $time, rsp, exp_head));

    a_rsp_latency: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_valid_d) |-> (since_acc == `TB_RSP_LAT))
        else stop_run($sformatf("Mismatch at %0t: rsp_valid after %0d cycles, expected %0d",
                                $time, since_acc, `TB_RSP_LAT));

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        held_q |-> (rsp_valid && rsp == rsp_q))
        else stop_run($sformatf("Mismatch at %0t: stalled rsp changed from %h to %h",
                                $time, rsp_q, rsp));

    a_busy_ready: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> !req_ready)
        else stop_run("req_ready went high while a division was still in flight");

    a_csr_ready: assert property (@(posedge clk) disable iff (rst) csr_ready)
        else stop_run("csr_ready went low although the register port never stalls");

    a_csr_rdata: assert property (@(posedge clk) disable iff (rst)
        csr_rvalid |-> (csr_rsp.rdata == exp_rdata))
        else stop_run($sformatf("Mismatch at %0t: register read %h, expected %h",
                                $time, csr_rsp.rdata, exp_rdata));

    // ------------------------------------------------------------------------
    // stimulus tasks, all entered on a rising edge
    // ------------------------------------------------------------------------
    task automatic send_pair(input div_in_t n, input div_in_t d);
        req_valid <= 1'b1;
        req       <= '{num: n, den: d};
        do @(posedge clk); while (!req_ready);  // accept edge
        req_valid <= 1'b0;
    endtask

    task automatic wait_idle();
        @(posedge clk);
        while (in_flight || rsp_valid) begin
            @(posedge clk);
        end
    endtask

    task automatic csr_write(input logic [1:0] addr, input logic [31:0] data);
        csr_valid <= 1'b1;
        csr_req   <= '{write: 1'b1, addr: addr, wdata: data};
        @(posedge clk);
        csr_valid <= 1'b0;
    endtask

    task automatic csr_read(input logic [1:0] addr, input logic [31:0] expected);
        csr_valid <= 1'b1;
        csr_req   <= '{write: 1'b0, addr: addr, wdata: '0};
        exp_rdata <= expected;
        n_rd      = n_rd + 1;
        @(posedge clk);
        csr_valid <= 1'b0;
        do @(posedge clk); while (!csr_rvalid);
    endtask

    // CTRL change only between transactions, sat_en feeds rsp combinationally
    task automatic set_ctrl(input logic sat, input logic zpol);
        wait_idle();
        sat_en_m <= sat;
        zpol_m   <= zpol;
        csr_write(`DIV_ADDR_CTRL, {30'b0, zpol, sat});
    endtask

    function automatic div_in_t small_den();
        div_in_t d;
        d = 16'($urandom_range(1, 255));     // below 1.0, pushes quotients out of range
        return ($urandom_range(0, 1) != 0) ? -d : d;
    endfunction

    initial begin
        logic [1:0] ctrl_val;
        seed_val  = $urandom(`TB_SEED);
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        csr_valid = 1'b0;
        csr_req   = '0;
        exp_rdata = '0;
        bp_en     = 1'b0;
        sat_en_m  = 1'b1;                   // CTRL reset value
        zpol_m    = 1'b0;
        n_rd      = 0;
        repeat (10) @(posedge clk);
        rst   <= 1'b0;
        bp_en <= 1'b1;
        @(posedge clk);

        // -128.0 corners, then random pairs
        send_pair(16'sh8000, 16'sh0100);
        send_pair(16'sh8000, 16'sh8000);
        send_pair(16'sh0100, 16'sh8000);
        send_pair(16'sh8000, 16'sh7fff);
        send_pair(16'sh8000, 16'shff00);
        send_pair(16'sh7fff, 16'sh8000);
        repeat (100) send_pair(16'($urandom), 16'($urandom));

        // out of range, clamp then wrap
        for (int s = 1; s >= 0; s--) begin
            set_ctrl(s[0], 1'b0);
            repeat (15) send_pair(16'($urandom), small_den());
        end

        // zero denominator under both policies
        for (int z = 0; z < 2; z++) begin
            for (int s = 0; s < 2; s++) begin
                set_ctrl(s[0], z[0]);
                send_pair(16'sh1234, 16'sh0000);
                send_pair(16'shc000, 16'sh0000);
                send_pair(16'sh0000, 16'sh0000);
                send_pair(16'sh8000, 16'sh0000);
            end
        end

        // counters, clear, CTRL readback
        wait_idle();
        csr_read(`DIV_ADDR_STAT, {n_sat[15:0], n_done[15:0]});
        csr_read(`DIV_ADDR_STAT + 2'd1, 32'(n_zero));
        csr_write(`DIV_ADDR_STAT, 32'($urandom));
        csr_read(`DIV_ADDR_STAT, 32'd0);
        csr_read(`DIV_ADDR_STAT + 2'd1, 32'd0);
        ctrl_val = 2'($urandom);
        set_ctrl(ctrl_val[0], ctrl_val[1]);
        csr_read(`DIV_ADDR_CTRL, {30'b0, ctrl_val});

        repeat (2) @(posedge clk);
        if (sb_q.size() != 0 || n_rsp != n_acc || n_rvalid != n_rd) begin
            stop_run("run ended with results or register reads still missing");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: div_unit_top.f
+incdir+hdl
+incdir+testbench
hdl/fxp_pkg.sv
hdl/div_csr_pkg.sv
hdl/divu_core.sv
hdl/q_convert.sv
hdl/fxp_signed_div.sv
hdl/div_csr.sv
hdl/div_unit_top.sv
testbench/tb_div_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator
# exit status is nonzero when the testbench fails
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_div_unit \
    --Mdir obj_dir \
    -o sim_div_unit \
    -f div_unit_top.f

./obj_dir/sim_div_unit
